/* access_sequencer.sv */
// APB slave that forwards each transfer to the fabric word-access port.
// The request is held back a fixed number of cycles; a disabled bridge answers with an error.
module access_sequencer
   import efpga_glue_pkg::*;
(
   input  logic                  asic_clk_i,
   input  logic                  rst_n,
   input  logic                  enable_apb_i,
   input  apb_req_t              apb_i,
   output logic [DATA_WIDTH-1:0] prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,
   output logic                  fab_req_valid_o,
   output fab_req_t              fab_req_o,
   input  fab_rsp_t              fab_rsp_i
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HOLD,
      ST_REQUEST,
      ST_RESPONSE,
      ST_DONE
   } seq_state_e;

   seq_state_e                state_q;
   seq_state_e                state_d;
   logic                      apb_setup;
   logic                      err_q;
   logic [DATA_WIDTH-1:0]     rdata_q;
   logic                      hold_en;
   logic                      hold_clr;
   logic                      hold_done;
   logic [HOLD_CNT_WIDTH-1:0] hold_cnt;

   assign apb_setup = apb_i.psel && !apb_i.penable;

   // setup cycle counts as the first hold cycle
   assign hold_en   = (state_q == ST_HOLD) ||
                      ((state_q == ST_IDLE) && apb_setup && enable_apb_i);
   assign hold_clr  = (state_q != ST_IDLE) && (state_q != ST_HOLD);
   assign hold_done = (hold_cnt == HOLD_CNT_WIDTH'(GRANT_HOLD_CYCLES));

   cycle_counter #(
      .WIDTH (HOLD_CNT_WIDTH)
   ) i_hold_cnt (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .en_i       (hold_en),
      .clr_i      (hold_clr),
      .count_o    (hold_cnt)
   );

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         ST_IDLE: begin
            if (apb_setup) begin
               state_d = enable_apb_i ? ST_HOLD : ST_DONE;  // disabled goes straight to error
            end
         end
         ST_HOLD: begin
            if (hold_done) begin
               state_d = ST_REQUEST;
            end
         end
         ST_REQUEST: begin
            if (fab_rsp_i.gnt) begin
               state_d = ST_RESPONSE;
            end
         end
         ST_RESPONSE: begin
            if (fab_rsp_i.valid) begin
               state_d = ST_DONE;
            end
         end
         ST_DONE: state_d = ST_IDLE;
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= ST_IDLE;
         err_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         if ((state_q == ST_IDLE) && apb_setup) begin
            err_q <= !enable_apb_i;  // one verdict per transfer
         end
      end
   end

   always_ff @(posedge asic_clk_i) begin
      if ((state_q == ST_RESPONSE) && fab_rsp_i.valid) begin
         rdata_q <= fab_rsp_i.rdata;
      end
   end

   // master keeps the APB fields stable, so the request follows them directly
   assign fab_req_o.addr  = apb_i.paddr[FAB_ADDR_WIDTH-1:0];
   assign fab_req_o.wen   = ~apb_i.pwrite;
   assign fab_req_o.wdata = apb_i.pwdata;
   assign fab_req_valid_o = (state_q == ST_REQUEST);

   assign pready_o  = (state_q == ST_DONE);
   assign pslverr_o = pready_o && err_q;
   assign prdata_o  = (pready_o && !err_q) ? rdata_q : '0;

   a_req_stable: assert property (
      @(posedge asic_clk_i) disable iff (!rst_n)
      (fab_req_valid_o && !fab_rsp_i.gnt) |=> $stable(fab_req_o))
      else $error("fab_req_o changed before the grant");

   a_pready_in_access: assert property (
      @(posedge asic_clk_i) disable iff (!rst_n)
      pready_o |-> (apb_i.psel && apb_i.penable))
      else $error("pready_o outside an APB access phase");

endmodule

/* control_qualifier.sv */
// Control word filter in front of the fabric.
// A word is forwarded only once it has been sampled unchanged three times in a row.
module control_qualifier
   import efpga_glue_pkg::*;
(
   input  logic                  asic_clk_i,
   input  logic                  rst_n,
   input  logic [CTRL_WIDTH-1:0] control_i,
   output logic [CTRL_WIDTH-1:0] control_o
);

   logic [CTRL_WIDTH-1:0] ctrl_d1;
   logic [CTRL_WIDTH-1:0] ctrl_d2;
   logic                  ctrl_stable;

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_d1     <= '0;
         ctrl_d2     <= '0;
         ctrl_stable <= 1'b0;
      end else begin
         ctrl_d1     <= control_i;
         ctrl_d2     <= ctrl_d1;
         ctrl_stable <= (ctrl_d1 == control_i) && (ctrl_d2 == control_i);  // 3 equal samples
      end
   end

   // d1 still holds the third sample when the flag is seen
   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         control_o <= '0;
      end else if (ctrl_stable) begin
         control_o <= ctrl_d1;
      end
   end

endmodule

/* cycle_counter.sv */
// Free-running wrapping counter with enable and synchronous clear.
// Serves as the performance counter and as the request hold timer.
module cycle_counter
   import efpga_glue_pkg::*;
#(
   parameter int unsigned WIDTH = PERF_WIDTH
) (
   input  logic             asic_clk_i,
   input  logic             rst_n,
   input  logic             en_i,
   input  logic             clr_i,
   output logic [WIDTH-1:0] count_o
);

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         count_o <= '0;
      end else if (clr_i) begin
         count_o <= '0;                    // clear beats enable
      end else if (en_i) begin
         count_o <= count_o + WIDTH'(1);  // wraps at the top
      end
   end

endmodule

/* efpga_glue.sv */
// SoC-clock glue around the embedded FPGA fabric.
// Control qualification, APB bridge, event edges and a performance counter.
module efpga_glue
   import efpga_glue_pkg::*;
(
   input  logic                  asic_clk_i,
   input  logic                  rst_n,

   input  logic [CTRL_WIDTH-1:0] control_i,
   output logic [CTRL_WIDTH-1:0] control_o,

   input  logic                  enable_events_i,
   input  logic [N_EVENTS-1:0]   fab_event_i,
   output logic [N_EVENTS-1:0]   event_o,

   // APB slave and fabric word port
   input  logic                  enable_apb_i,
   input  apb_req_t              apb_i,
   output logic [DATA_WIDTH-1:0] prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,
   output logic                  fab_req_valid_o,
   output fab_req_t              fab_req_o,
   input  fab_rsp_t              fab_rsp_i,

   input  logic                  enable_perf_i,
   input  logic                  clear_perf_i,
   output logic [PERF_WIDTH-1:0] perf_count_o
);

   control_qualifier i_control_qualifier (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .control_i  (control_i),
      .control_o  (control_o)
   );

   event_edge_unit i_event_edge_unit (
      .asic_clk_i      (asic_clk_i),
      .rst_n           (rst_n),
      .enable_events_i (enable_events_i),
      .fab_event_i     (fab_event_i),
      .event_o         (event_o)
   );

   access_sequencer i_access_sequencer (
      .asic_clk_i      (asic_clk_i),
      .rst_n           (rst_n),
      .enable_apb_i    (enable_apb_i),
      .apb_i           (apb_i),
      .prdata_o        (prdata_o),
      .pready_o        (pready_o),
      .pslverr_o       (pslverr_o),
      .fab_req_valid_o (fab_req_valid_o),
      .fab_req_o       (fab_req_o),
      .fab_rsp_i       (fab_rsp_i)
   );

   // cycle count for software profiling
   cycle_counter #(
      .WIDTH (PERF_WIDTH)
   ) i_perf_counter (
      .asic_clk_i (asic_clk_i),
      .rst_n      (rst_n),
      .en_i       (enable_perf_i),
      .clr_i      (clear_perf_i),
      .count_o    (perf_count_o)
   );

endmodule

/* efpga_glue_pkg.sv */
// Widths, timing constants and bus structs shared by the eFPGA glue logic.
// Every glue module takes these with a wildcard import.
package efpga_glue_pkg;

   // control word and events
   localparam int unsigned CTRL_WIDTH = 32;
   localparam int unsigned N_EVENTS   = 16;

   // register access path
   localparam int unsigned APB_ADDR_WIDTH = 32;
   localparam int unsigned FAB_ADDR_WIDTH = 20;  // low paddr bits seen by the fabric
   localparam int unsigned DATA_WIDTH     = 32;

   // request hold before the fabric sees it
   localparam int unsigned GRANT_HOLD_CYCLES = 3;
   localparam int unsigned HOLD_CNT_WIDTH    = 2;  // must hold GRANT_HOLD_CYCLES

   localparam int unsigned PERF_WIDTH = 32;

   // fabric word-access request, 53 bits
   typedef struct packed {
      logic [FAB_ADDR_WIDTH-1:0] addr;
      logic                      wen;    // low means write
      logic [DATA_WIDTH-1:0]     wdata;
   } fab_req_t;

   // fabric response, 34 bits
   typedef struct packed {
      logic                  gnt;    // ends the request
      logic                  valid;  // rdata strobe, reads and writes
      logic [DATA_WIDTH-1:0] rdata;
   } fab_rsp_t;

   // APB3 master to slave signals, 67 bits
   typedef struct packed {
      logic                      psel;
      logic                      penable;
      logic                      pwrite;
      logic [APB_ADDR_WIDTH-1:0] paddr;
      logic [DATA_WIDTH-1:0]     pwdata;
   } apb_req_t;

endpackage

/* event_edge_unit.sv */
// Fabric event capture on the SoC clock.
// Levels are gated, synchronized and turned into one-cycle rising-edge pulses.
module event_edge_unit
   import efpga_glue_pkg::*;
(
   input  logic                asic_clk_i,
   input  logic                rst_n,
   input  logic                enable_events_i,
   input  logic [N_EVENTS-1:0] fab_event_i,
   output logic [N_EVENTS-1:0] event_o
);

   logic [N_EVENTS-1:0] event_gated;
   logic [N_EVENTS-1:0] sync_q1;
   logic [N_EVENTS-1:0] sync_q2;
   logic [N_EVENTS-1:0] sync_last;

   assign event_gated = fab_event_i & {N_EVENTS{enable_events_i}};

   always_ff @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         sync_q1   <= '0;
         sync_q2   <= '0;
         sync_last <= '0;
         event_o   <= '0;
      end else begin
         sync_q1   <= event_gated;
         sync_q2   <= sync_q1;              // synchronized level
         sync_last <= sync_q2;
         event_o   <= sync_q2 & ~sync_last;  // rising edge only
      end
   end

   // a held level must not stretch a pulse
   a_event_single_cycle: assert property (
      @(posedge asic_clk_i) disable iff (!rst_n)
      (event_o & $past(event_o)) == '0)
      else $error("event_o pulse lasted more than one cycle");

endmodule

/* project.f */
efpga_glue_pkg.sv
cycle_counter.sv
control_qualifier.sv
event_edge_unit.sv
access_sequencer.sv
efpga_glue.sv
tb_clock_gen.sv
tb_fabric_model.sv
tb_efpga_glue.sv

/* run.sh */
#!/bin/sh
# Build and run the eFPGA glue testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_efpga_glue -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* tb_clock_gen.sv */
// Testbench clock and reset source.
// Reset is released one time unit after the last reset edge.
module tb_clock_gen #(
   parameter int HALF_PERIOD  = 5,
   parameter int RESET_CYCLES = 2
) (
   output logic asic_clk_o,
   output logic rst_n
);

   initial begin
      asic_clk_o = 1'b0;
      forever #HALF_PERIOD asic_clk_o = ~asic_clk_o;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge asic_clk_o);
      #1;
      rst_n = 1'b1;
   end

endmodule

/* tb_efpga_glue.sv */
// Testbench top for the eFPGA glue logic.
// Drives APB, control, event and counter stimulus and checks against reference models.
module tb_efpga_glue
   import efpga_glue_pkg::*;
();

   localparam logic [31:0] SEED_INIT      = 32'hdd0e_6c2c;
   localparam int          TIMEOUT_CYCLES = 100;
   localparam int          MIN_LATENCY    = GRANT_HOLD_CYCLES + 3;

   logic                  asic_clk;
   logic                  rst_n;
   logic [CTRL_WIDTH-1:0] control_in;
   logic [CTRL_WIDTH-1:0] control_out;
   logic                  enable_events;
   logic [N_EVENTS-1:0]   fab_event;
   logic [N_EVENTS-1:0]   event_out;
   logic                  enable_apb;
   apb_req_t              apb_req;
   logic [DATA_WIDTH-1:0] prdata;
   logic                  pready;
   logic                  pslverr;
   logic                  fab_req_valid;
   fab_req_t              fab_req;
   fab_rsp_t              fab_rsp;
   logic                  enable_perf;
   logic                  clear_perf;
   logic [PERF_WIDTH-1:0] perf_count;

   int                    seed;
   logic [31:0]           rnd;
   logic [3:0]            idx;
   logic [31:0]           wdata;
   logic [31:0]           rdata;
   logic                  err;
   int                    latency;
   int                    valid_before;
   logic [31:0]           ctrl_val [5];
   logic [DATA_WIDTH-1:0] shadow [16];

   string                 cur_test;
   int                    total_checks;
   int                    total_errors;
   int                    test_errors;
   string                 chk_name_q [$];
   logic [63:0]           chk_exp_q [$];
   logic [63:0]           chk_act_q [$];
   string                 cmp_name;
   logic [63:0]           cmp_exp;
   logic [63:0]           cmp_act;

   logic [CTRL_WIDTH-1:0] ctrl_h1;
   logic [CTRL_WIDTH-1:0] ctrl_h2;
   logic [CTRL_WIDTH-1:0] ctrl_h3;
   logic [CTRL_WIDTH-1:0] exp_control;
   logic [N_EVENTS-1:0]   gated;
   logic [N_EVENTS-1:0]   rises;
   logic [N_EVENTS-1:0]   ev_h1;
   logic [N_EVENTS-1:0]   ev_h2;
   logic [N_EVENTS-1:0]   ev_h3;
   logic [N_EVENTS-1:0]   exp_event;
   logic                  count_events;
   int                    exp_edges [N_EVENTS];
   int                    seen_pulses [N_EVENTS];
   int                    req_valid_cycles;
   logic                  req_pending;
   fab_req_t              held_req;

   tb_clock_gen #(
      .HALF_PERIOD  (5),
      .RESET_CYCLES (2)
   ) i_clock_gen (
      .asic_clk_o (asic_clk),
      .rst_n      (rst_n)
   );

   tb_fabric_model #(
      .SEED (SEED_INIT)
   ) i_fabric (
      .asic_clk_i  (asic_clk),
      .rst_n       (rst_n),
      .req_valid_i (fab_req_valid),
      .req_i       (fab_req),
      .rsp_o       (fab_rsp)
   );

   efpga_glue DUT (
      .asic_clk_i      (asic_clk),
      .rst_n           (rst_n),
      .control_i       (control_in),
      .control_o       (control_out),
      .enable_events_i (enable_events),
      .fab_event_i     (fab_event),
      .event_o         (event_out),
      .enable_apb_i    (enable_apb),
      .apb_i           (apb_req),
      .prdata_o        (prdata),
      .pready_o        (pready),
      .pslverr_o       (pslverr),
      .fab_req_valid_o (fab_req_valid),
      .fab_req_o       (fab_req),
      .fab_rsp_i       (fab_rsp),
      .enable_perf_i   (enable_perf),
      .clear_perf_i    (clear_perf),
      .perf_count_o    (perf_count)
   );

   // output after edge n, from the samples at edges n-1 to n-3
   function automatic logic [CTRL_WIDTH-1:0] qualified_control(
         input logic [CTRL_WIDTH-1:0] prev,
         input logic [CTRL_WIDTH-1:0] s1, input logic [CTRL_WIDTH-1:0] s2,
         input logic [CTRL_WIDTH-1:0] s3);
      return ((s1 == s2) && (s2 == s3)) ? s1 : prev;
   endfunction

   function automatic logic [N_EVENTS-1:0] rising_bits(input logic [N_EVENTS-1:0] prev,
         input logic [N_EVENTS-1:0] cur);
      return cur & ~prev;
   endfunction

   function automatic fab_req_t fab_req_of(input apb_req_t a);
      fab_req_t r;
      r.addr  = a.paddr[FAB_ADDR_WIDTH-1:0];
      r.wen   = !a.pwrite;  // low means write
      r.wdata = a.pwdata;
      return r;
   endfunction

   function automatic logic [DATA_WIDTH-1:0] shadow_word(input logic [3:0] i);
      return shadow[i];
   endfunction

   task automatic push_check(input string name, input logic [63:0] exp, input logic [63:0] act);
      chk_name_q.push_back(name);
      chk_exp_q.push_back(exp);
      chk_act_q.push_back(act);
   endtask

   task automatic report_problem(input string msg);
      $display("%s in test %s", msg, cur_test);
      total_errors++;
      test_errors++;
   endtask

   task automatic abort_run(input string msg);
      $display("%s in test %s, run stopped", msg, cur_test);
      $display("** FAIL **");
      $finish;
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic finish_test();
      int n;
      n = 0;
      while ((chk_name_q.size() > 0) && (n < TIMEOUT_CYCLES)) begin
         @(negedge asic_clk);
         n++;
      end
      if (chk_name_q.size() > 0) abort_run("pending checks were never compared");
      $display("test %s finished with %0d errors", cur_test, test_errors);
   endtask

   // one APB3 transfer; latency counts edges from setup to the pready edge
   task automatic apb_transfer(input logic write, input logic [31:0] addr,
         input logic [31:0] data, output logic [31:0] rd, output logic slverr, output int lat);
      int n;
      @(posedge asic_clk);
      #1;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = data;
      @(posedge asic_clk);
      #1;
      apb_req.penable = 1'b1;
      n = 1;
      do begin
         @(negedge asic_clk);
         n++;
      end while (!pready && (n < TIMEOUT_CYCLES));
      if (!pready) abort_run("APB transfer never saw pready");
      rd     = prdata;
      slverr = pslverr;
      lat    = n - 1;
      @(posedge asic_clk);
      #1;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
   endtask

   task automatic drive_control(input logic [CTRL_WIDTH-1:0] value, input int cycles);
      repeat (cycles) begin
         @(posedge asic_clk);
         #1;
         control_in = value;
         @(negedge asic_clk);
         push_check("control_o", 64'(exp_control), 64'(control_out));
      end
   endtask

   task automatic run_perf(input int n);
      @(posedge asic_clk);
      #1;
      clear_perf  = 1'b1;
      enable_perf = 1'b0;
      @(posedge asic_clk);
      #1;
      clear_perf  = 1'b0;
      enable_perf = 1'b1;
      repeat (n) @(posedge asic_clk);
      #1;
      enable_perf = 1'b0;
      @(negedge asic_clk);
      push_check("perf_count", 64'(n), 64'(perf_count));
   endtask

   // reference models, sampled where the DUT samples
   always @(posedge asic_clk or negedge rst_n) begin
      if (!rst_n) begin
         {ctrl_h1, ctrl_h2, ctrl_h3, exp_control} = '0;
         {ev_h1, ev_h2, ev_h3, exp_event} = '0;
      end else begin
         exp_control = qualified_control(exp_control, ctrl_h1, ctrl_h2, ctrl_h3);
         ctrl_h3 = ctrl_h2;
         ctrl_h2 = ctrl_h1;
         ctrl_h1 = control_in;
         gated     = fab_event & {N_EVENTS{enable_events}};
         exp_event = rising_bits(ev_h3, ev_h2);  // pulse two edges after the first high sample
         rises     = rising_bits(ev_h1, gated);
         if (count_events) begin
            for (int k = 0; k < N_EVENTS; k++) begin
               if (rises[k]) exp_edges[k]++;
            end
         end
         ev_h3 = ev_h2;
         ev_h2 = ev_h1;
         ev_h1 = gated;
      end
   end

   // compare process
   always @(posedge asic_clk) begin
      while (chk_name_q.size() > 0) begin
         cmp_name = chk_name_q.pop_front();
         cmp_exp  = chk_exp_q.pop_front();
         cmp_act  = chk_act_q.pop_front();
         total_checks++;
         assert (cmp_act === cmp_exp)
         else begin
            $display("[FAIL] %s: %s expected %0h actual %0h", cur_test, cmp_name, cmp_exp,
                     cmp_act);
            total_errors++;
            test_errors++;
         end
      end
   end

   // fabric request monitor and pulse counter
   always @(negedge asic_clk) begin
      if (rst_n) begin
         if (fab_req_valid) begin
            req_valid_cycles++;
            if (req_pending) begin
               assert (fab_req === held_req)
               else report_problem("fabric request changed before its grant");
            end
            assert (fab_req === fab_req_of(apb_req))
            else report_problem("fabric request does not match the APB transfer");
            req_pending = !fab_rsp.gnt;
            held_req    = fab_req;
         end else begin
            req_pending = 1'b0;
         end
         if (count_events) begin
            for (int k = 0; k < N_EVENTS; k++) begin
               if (event_out[k]) seen_pulses[k]++;
            end
         end
      end
   end

   initial begin
      seed          = SEED_INIT;
      cur_test      = "reset";
      control_in    = '0;
      enable_events = 1'b0;
      fab_event     = '0;
      enable_apb    = 1'b0;
      apb_req       = '0;
      enable_perf   = 1'b0;
      clear_perf    = 1'b0;
      count_events  = 1'b0;
      total_checks  = 0;
      total_errors  = 0;
      req_valid_cycles = 0;
      req_pending   = 1'b0;
      latency       = 0;
      while (!rst_n && (latency < TIMEOUT_CYCLES)) begin
         @(posedge asic_clk);
         latency++;
      end
      if (!rst_n) abort_run("reset was never released");

      start_test("reset_values");
      @(negedge asic_clk);
      push_check("outputs", 64'(0), 64'({fab_req_valid, pready, pslverr, event_out}));
      push_check("control_o", 64'(0), 64'(control_out));
      push_check("perf_count", 64'(0), 64'(perf_count));
      finish_test();

      start_test("write_read");
      enable_apb = 1'b1;
      for (int i = 0; i < 24; i++) begin
         rnd   = $random(seed);
         idx   = (i < 16) ? 4'(i) : rnd[3:0];  // every word once, then overwrites
         wdata = $random(seed);
         apb_transfer(1'b1, {rnd[31:4], idx}, wdata, rdata, err, latency);
         shadow[idx] = wdata;
         push_check("write pslverr", 64'(0), 64'(err));
      end
      for (int i = 0; i < 16; i++) begin
         rnd = $random(seed);
         idx = 4'(i);
         apb_transfer(1'b0, {rnd[31:4], idx}, rnd, rdata, err, latency);
         push_check($sformatf("read word %0d", i), 64'(shadow_word(idx)), 64'(rdata));
         push_check("read pslverr", 64'(0), 64'(err));
      end
      finish_test();

      start_test("disabled_bridge");
      @(posedge asic_clk);
      #1;
      enable_apb   = 1'b0;
      valid_before = req_valid_cycles;
      repeat (6) begin
         rnd   = $random(seed);
         wdata = $random(seed);
         apb_transfer(rnd[8], rnd, wdata, rdata, err, latency);  // must not reach the memory
         push_check("pslverr", 64'(1), 64'(err));
         push_check("prdata", 64'(0), 64'(rdata));
      end
      push_check("fabric request cycles", 64'(valid_before), 64'(req_valid_cycles));
      finish_test();

      start_test("hold_backpressure");
      @(posedge asic_clk);
      #1;
      enable_apb = 1'b1;
      repeat (20) begin
         rnd   = $random(seed);
         idx   = rnd[3:0];
         wdata = $random(seed);
         apb_transfer(rnd[4], rnd, wdata, rdata, err, latency);
         if (rnd[4]) begin
            shadow[idx] = wdata;
         end else begin
            push_check("read data", 64'(shadow_word(idx)), 64'(rdata));
         end
         push_check("pslverr", 64'(0), 64'(err));
         assert (latency >= MIN_LATENCY)
         else report_problem($sformatf("pready came %0d cycles after setup", latency));
      end
      finish_test();

      start_test("control_qualify");
      for (int i = 0; i < 5; i++) begin
         ctrl_val[i] = $random(seed);
      end
      drive_control(ctrl_val[0], 6);
      push_check("held value", 64'(ctrl_val[0]), 64'(control_out));
      drive_control(ctrl_val[1], 1);
      drive_control(ctrl_val[0], 3);
      drive_control(ctrl_val[2], 2);
      drive_control(ctrl_val[0], 4);
      drive_control(ctrl_val[3], 6);
      drive_control(ctrl_val[4], 1);
      drive_control(ctrl_val[3], 4);
      push_check("final value", 64'(ctrl_val[3]), 64'(control_out));
      finish_test();

      start_test("event_pulses");
      for (int k = 0; k < N_EVENTS; k++) begin
         exp_edges[k]   = 0;
         seen_pulses[k] = 0;
      end
      count_events = 1'b1;
      for (int i = 0; i < 86; i++) begin
         @(posedge asic_clk);
         #1;
         rnd = $random(seed);
         fab_event     = (i < 80) ? (rnd[15:0] ^ rnd[31:16]) : '0;  // quiet tail
         enable_events = (rnd[22:20] != 3'd0);
         @(negedge asic_clk);
         push_check("event_o", 64'(exp_event), 64'(event_out));
      end
      count_events = 1'b0;
      for (int k = 0; k < N_EVENTS; k++) begin
         push_check($sformatf("pulses on line %0d", k), 64'(exp_edges[k]), 64'(seen_pulses[k]));
      end
      finish_test();

      start_test("perf_counter");
      run_perf(7);
      rnd = $random(seed);
      run_perf(int'(rnd[5:0]) + 5);
      @(posedge asic_clk);
      #1;
      enable_perf = 1'b1;
      clear_perf  = 1'b1;  // clear wins over enable
      @(posedge asic_clk);
      #1;
      enable_perf = 1'b0;
      clear_perf  = 1'b0;
      @(negedge asic_clk);
      push_check("perf after clear", 64'(0), 64'(perf_count));
      finish_test();

      $display("checks %0d, errors %0d", total_checks, total_errors);
      if (total_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

/* tb_fabric_model.sv */
// Fabric word-access port model for the testbench.
// 16-word memory, grant after a random 0 to 4 cycles, valid one cycle after the grant.
module tb_fabric_model
   import efpga_glue_pkg::*;
#(
   parameter logic [31:0] SEED = 32'h0000_0001
) (
   input  logic     asic_clk_i,
   input  logic     rst_n,
   input  logic     req_valid_i,
   input  fab_req_t req_i,
   output fab_rsp_t rsp_o
);

   logic [DATA_WIDTH-1:0] mem [16];
   logic [2:0]            delay_left;
   logic [31:0]           rnd;
   int                    seed;

   // every word differs from every other one after reset
   function automatic logic [DATA_WIDTH-1:0] fill_word(input int idx);
      return (32'(idx) * 32'h0101_0101) ^ 32'h5a3c_c3a5;
   endfunction

   always @(posedge asic_clk_i or negedge rst_n) begin
      if (!rst_n) begin
         seed = SEED;
         rsp_o      <= '0;
         delay_left <= 3'd0;
         for (int i = 0; i < 16; i++) begin
            mem[i] <= fill_word(i);
         end
      end else begin
         rsp_o.valid <= 1'b0;
         if (rsp_o.gnt) begin
            rsp_o.gnt   <= 1'b0;
            rsp_o.valid <= 1'b1;  // one cycle after the grant
            if (!req_i.wen) begin
               mem[req_i.addr[3:0]] <= req_i.wdata;
               rsp_o.rdata          <= req_i.wdata;
            end else begin
               rsp_o.rdata <= mem[req_i.addr[3:0]];
            end
            rnd = $unsigned($random(seed)) % 32'd5;
            delay_left <= rnd[2:0];  // delay for the next request
         end else if (req_valid_i) begin
            if (delay_left == 3'd0) begin
               rsp_o.gnt <= 1'b1;
            end else begin
               delay_left <= delay_left - 3'd1;
            end
         end
      end
   end

endmodule
